// ==== src/dreq_pkg.sv ====
/* dual-request router shared types */

package dreq_pkg;

    // ##########################################################
    // widths
    // ##########################################################

    localparam int dest_bits       = 4;  // logical destination field, also one remap entry
    localparam int n_logical_dests = 16; // remap table depth, one entry per logical dest
    localparam int vaddr_bits      = 32; // virtual address of a sub-request
    localparam int len_bits        = 16; // transfer length of a sub-request
    localparam int drop_count_bits = 16; // saturating drop counter width

    // ##########################################################
    // enums
    // ##########################################################

    // operation carried by one sub-request
    typedef enum logic [1:0] {
        op_read  = 2'd0, // host read
        op_write = 2'd1, // host write
        op_sync  = 2'd2  // ordering barrier
    } req_opcode_e;

    // selects which configuration register a strobe updates
    typedef enum logic [0:0] {
        cfg_map_entry   = 1'b0, // cfg_addr is a logical dest, cfg_data the physical port
        cfg_port_enable = 1'b1  // cfg_addr is a physical port, cfg_data[0] its enable
    } cfg_target_e;

    // ##########################################################
    // payload
    // ##########################################################

    // one sub-request, 55 bits
    typedef struct packed {
        logic                  actv;   // this sub-request carries the routing dest
        req_opcode_e           opcode; // operation type
        logic [dest_bits-1:0]  dest;   // logical destination
        logic [vaddr_bits-1:0] vaddr;  // start address
        logic [len_bits-1:0]   len;    // length in bytes
    } sub_req_t;

    // a full request word, req_1 sits in the upper bits, 110 bits in all
    typedef struct packed {
        sub_req_t req_1; // first sub-request, takes priority when active
        sub_req_t req_2; // second sub-request, used when req_1 is idle
    } dreq_t;

endpackage

// ==== src/meta_reg.sv ====
/* two-entry registered stream slice */

`timescale 1ns/1ns

module meta_reg #(
    parameter int data_bits = 32 // payload width of the stream
) (
    input  logic                 aclk,
    input  logic                 reset,

    // upstream side
    input  logic                 s_valid,
    output logic                 s_ready,
    input  logic [data_bits-1:0] s_data,

    // downstream side
    output logic                 m_valid,
    input  logic                 m_ready,
    output logic [data_bits-1:0] m_data
);

    // ##########################################################
    // storage
    // ##########################################################

    logic                 out_valid_q;  // output register holds an item
    logic [data_bits-1:0] out_data_q;   // item presented downstream
    logic                 skid_valid_q; // skid register holds an item
    logic [data_bits-1:0] skid_data_q;  // item caught while downstream stalled
    logic                 ready_q;      // registered ready, always the inverse of skid_valid_q

    logic push; // an upstream transfer happens this cycle
    logic load; // the output register may take a new item this cycle

    assign push = s_valid && ready_q;      // ready comes straight from a flop
    assign load = !out_valid_q || m_ready; // empty, or the current item leaves now

    // ##########################################################
    // control
    // ##########################################################

    always_ff @(posedge aclk) begin
        if (reset) begin
            out_valid_q  <= 1'b0;
            skid_valid_q <= 1'b0;
            ready_q      <= 1'b1; // both entries empty, so accept at once
        end else if (load) begin
            if (skid_valid_q) begin
                out_valid_q  <= 1'b1; // the skid item moves forward
                skid_valid_q <= 1'b0;
                ready_q      <= 1'b1; // skid is free again next cycle
            end else begin
                out_valid_q <= push; // straight through, one cycle of latency
            end
        end else if (push) begin
            skid_valid_q <= 1'b1; // output stalled, park the new item
            ready_q      <= 1'b0; // both entries now busy
        end
    end

    // payload registers follow the control decisions above
    always_ff @(posedge aclk) begin
        if (load) begin
            if (skid_valid_q) begin
                out_data_q <= skid_data_q; // older item goes first to keep order
            end else if (push) begin
                out_data_q <= s_data;
            end
        end
        if (!load && push) begin
            skid_data_q <= s_data;
        end
    end

    assign s_ready = ready_q;
    assign m_valid = out_valid_q;
    assign m_data  = out_data_q;

endmodule

// ==== src/dest_map_regs.sv ====
/* remap table and drop counter */

`timescale 1ns/1ns

module dest_map_regs import dreq_pkg::*; #(
    parameter int n_dests   = 4, // number of physical output ports
    parameter int port_bits = 2  // index width of a physical port
) (
    input  logic                                 aclk,
    input  logic                                 reset,

    // configuration strobe, one cycle and never stalled
    input  logic                                 cfg_wr,
    input  cfg_target_e                          cfg_target,
    input  logic [dest_bits-1:0]                 cfg_addr,
    input  logic [dest_bits-1:0]                 cfg_data,

    // one pulse per dropped request from the router
    input  logic                                 drop_pulse,

    // routing state toward the router
    output logic [n_logical_dests*dest_bits-1:0] map_table,
    output logic [n_dests-1:0]                   port_enable,

    // status
    output logic [drop_count_bits-1:0]           drop_count
);

    // ##########################################################
    // remap table
    // ##########################################################

    logic [dest_bits-1:0] map_q [n_logical_dests]; // physical port for each logical dest
    logic                 map_wr;                  // strobe targets a table entry
    logic                 en_wr;                   // strobe targets an existing port enable

    assign map_wr = cfg_wr && (cfg_target == cfg_map_entry);
    // enable addresses past the last port have no register behind them
    assign en_wr  = cfg_wr && (cfg_target == cfg_port_enable) && (cfg_addr < n_dests);

    always_ff @(posedge aclk) begin
        if (reset) begin
            for (int i = 0; i < n_logical_dests; i++) begin
                map_q[i] <= dest_bits'(i % n_dests); // spread logical dests round robin
            end
        end else if (map_wr) begin
            map_q[cfg_addr] <= cfg_data; // stored as given, even a nonexistent port
        end
    end

    // flatten so the router sees a plain bit vector, entry i at bits [4i+3:4i]
    for (genvar i = 0; i < n_logical_dests; i++) begin : g_flat
        assign map_table[i*dest_bits +: dest_bits] = map_q[i];
    end

    // ##########################################################
    // port enables
    // ##########################################################

    logic [n_dests-1:0] enable_q; // one bit per physical port

    always_ff @(posedge aclk) begin
        if (reset) begin
            enable_q <= '1; // every port open after reset
        end else if (en_wr) begin
            enable_q[cfg_addr[port_bits-1:0]] <= cfg_data[0];
        end
    end

    assign port_enable = enable_q;

    // ##########################################################
    // drop counter
    // ##########################################################

    logic [drop_count_bits-1:0] drop_q; // saturates at all ones

    always_ff @(posedge aclk) begin
        if (reset) begin
            drop_q <= '0;
        end else if (drop_pulse && (drop_q != '1)) begin
            drop_q <= drop_q + 1'b1; // the drop shows up the cycle after it was accepted
        end
    end

    assign drop_count = drop_q;

endmodule

// ==== src/dest_dreq_mux.sv ====
/* destination select and port demux */

`timescale 1ns/1ns

module dest_dreq_mux import dreq_pkg::*; #(
    parameter int n_dests   = 4, // number of physical output ports
    parameter int port_bits = 2  // index width of a physical port
) (
    input  logic                                 aclk,
    input  logic                                 reset,

    // upstream request stream
    input  logic                                 s_valid,
    output logic                                 s_ready,
    input  dreq_t                                s_data,

    // routing state from the configuration block
    input  logic [n_logical_dests*dest_bits-1:0] map_table,
    input  logic [n_dests-1:0]                   port_enable,

    // per-port output streams
    output logic [n_dests-1:0]                   m_valid,
    input  logic [n_dests-1:0]                   m_ready,
    output dreq_t [n_dests-1:0]                  m_data,

    // one cycle per dropped request
    output logic                                 drop_pulse
);

    // ##########################################################
    // destination lookup
    // ##########################################################

    logic [dest_bits-1:0] sel_dest;  // logical dest of the active sub-request
    logic [dest_bits-1:0] phys_port; // remapped physical port, may be out of range
    logic [port_bits-1:0] port_idx;  // physical port cut to index width
    logic                 in_range;  // the remapped port exists
    logic                 port_en;   // enable bit of the selected port
    logic                 drop;      // head request has nowhere to go

    logic [n_dests-1:0]   slice_valid; // valid toward each port slice
    logic [n_dests-1:0]   slice_ready; // ready back from each port slice

    // req_1 wins when its active flag is set, otherwise req_2 steers the word
    assign sel_dest  = s_data.req_1.actv ? s_data.req_1.dest : s_data.req_2.dest;
    assign phys_port = map_table[sel_dest*dest_bits +: dest_bits];
    assign port_idx  = phys_port[port_bits-1:0];
    assign in_range  = (phys_port < n_dests);

    always_comb begin
        port_en = 1'b0;
        for (int i = 0; i < n_dests; i++) begin
            if (port_idx == port_bits'(i)) begin
                port_en = port_enable[i];
            end
        end
    end

    assign drop = !in_range || !port_en;

    // ##########################################################
    // demux and handshake
    // ##########################################################

    always_comb begin
        s_ready = drop; // a drop is swallowed without waiting on any port
        for (int i = 0; i < n_dests; i++) begin
            slice_valid[i] = s_valid && !drop && (port_idx == port_bits'(i));
            if (!drop && (port_idx == port_bits'(i))) begin
                s_ready = slice_ready[i]; // only the addressed slice can stall the input
            end
        end
    end

    assign drop_pulse = s_valid && drop; // s_ready is high here, so this is a transfer

    // one two-entry slice per port keeps order and absorbs back-pressure
    for (genvar i = 0; i < n_dests; i++) begin : g_port
        meta_reg #(
            .data_bits($bits(dreq_t))
        ) meta_reg_inst (
            .aclk    (aclk),
            .reset   (reset),
            .s_valid (slice_valid[i]),
            .s_ready (slice_ready[i]),
            .s_data  (s_data),          // every slice sees the word, only one gets valid
            .m_valid (m_valid[i]),
            .m_ready (m_ready[i]),
            .m_data  (m_data[i])
        );
    end

endmodule

// ==== src/dreq_router_top.sv ====
/* dual-request router top level */

`timescale 1ns/1ns

module dreq_router_top import dreq_pkg::*; #(
    parameter int n_dests = 4 // physical output ports, legal range 1 to 16
) (
    input  logic                       aclk,
    input  logic                       reset,

    // upstream request stream
    input  logic                       s_valid,
    output logic                       s_ready,
    input  dreq_t                      s_data,

    // per-port output streams
    output logic [n_dests-1:0]         m_valid,
    input  logic [n_dests-1:0]         m_ready,
    output dreq_t [n_dests-1:0]        m_data,

    // configuration strobe
    input  logic                       cfg_wr,
    input  cfg_target_e                cfg_target,
    input  logic [dest_bits-1:0]       cfg_addr,
    input  logic [dest_bits-1:0]       cfg_data,

    // status
    output logic [drop_count_bits-1:0] drop_count
);

    // a single port still needs a one-bit index
    localparam int port_bits = (n_dests > 1) ? $clog2(n_dests) : 1;

    // ##########################################################
    // internal links
    // ##########################################################

    logic [n_logical_dests*dest_bits-1:0] map_table;   // flattened remap table
    logic [n_dests-1:0]                   port_enable; // per-port enable bits
    logic                                 drop_pulse;  // router reports one drop

    dest_map_regs #(
        .n_dests   (n_dests),
        .port_bits (port_bits)
    ) dest_map_regs_inst (
        .aclk        (aclk),
        .reset       (reset),
        .cfg_wr      (cfg_wr),
        .cfg_target  (cfg_target),
        .cfg_addr    (cfg_addr),
        .cfg_data    (cfg_data),
        .drop_pulse  (drop_pulse),
        .map_table   (map_table),
        .port_enable (port_enable),
        .drop_count  (drop_count)
    );

    dest_dreq_mux #(
        .n_dests   (n_dests),
        .port_bits (port_bits)
    ) dest_dreq_mux_inst (
        .aclk        (aclk),
        .reset       (reset),
        .s_valid     (s_valid),
        .s_ready     (s_ready),
        .s_data      (s_data),
        .map_table   (map_table),
        .port_enable (port_enable),
        .m_valid     (m_valid),
        .m_ready     (m_ready),
        .m_data      (m_data),
        .drop_pulse  (drop_pulse)
    );

endmodule

// ==== test/dreq_router_props.sv ====
/* router handshake assertions */

`timescale 1ns/1ns

module dreq_router_props import dreq_pkg::*; #(
    parameter int n_dests = 4 // number of physical output ports
) (
    input logic                aclk,
    input logic                reset,
    input logic                s_valid,     // upstream offers a word
    input logic                s_ready,     // router takes the offered word
    input logic [n_dests-1:0]  m_valid,
    input logic [n_dests-1:0]  m_ready,
    input dreq_t [n_dests-1:0] m_data,
    input logic [n_dests-1:0]  slice_valid, // valid offered to each port slice
    input logic [n_dests-1:0]  slice_ready, // ready returned by each port slice
    input logic                drop_pulse   // head request swallowed this cycle
);

    // ############################################################
    // reset and handshake rules
    // ############################################################

    // synchronous reset empties every slice by the next edge
    a_reset_clears: assert property (@(posedge aclk) reset |=> (m_valid == '0))
        else $error("m_valid not cleared after reset");

    for (genvar i = 0; i < n_dests; i++) begin : g_port
        // a stalled port keeps its item and its payload
        a_hold_stalled: assert property (@(posedge aclk) disable iff (reset)
            (m_valid[i] && !m_ready[i]) |=> (m_valid[i] && $stable(m_data[i])))
            else $error("port %0d changed while stalled", i);
    end

    // each accepted word lands in exactly one slice or in the drop counter
    // while the input is idle or stalled no slice takes a word and nothing is dropped
    a_one_target: assert property (@(posedge aclk) disable iff (reset)
        ($countones(slice_valid & slice_ready) + int'(drop_pulse)) == int'(s_valid && s_ready))
        else $error("accepted input word did not go to exactly one destination");

endmodule

// ==== test/dreq_router_tb.sv ====
/* dual-request router testbench */

`timescale 1ns/1ns

module dreq_router_tb import dreq_pkg::*;;

    localparam int n_dests       = 4;   // ports of the DUT under test
    localparam int reset_cycles  = 5;
    localparam int n_basic       = 32;  // identity map requests
    localparam int n_remap       = 32;  // requests after the table rewrite
    localparam int n_disable     = 32;  // requests with one port switched off
    localparam int n_random      = 400; // random traffic with back-pressure
    // directed requests take one cycle each, random ones about two, plus writes and idles
    localparam int stim_cycles   = reset_cycles + n_basic + n_remap + n_disable
                                   + 2 * n_random + 60;
    localparam int timeout_limit = 2 * stim_cycles + 200;

    logic                       aclk = 1'b0;
    logic                       reset;
    logic                       s_valid;
    logic                       s_ready;
    dreq_t                      s_data;
    logic [n_dests-1:0]         m_valid;
    logic [n_dests-1:0]         m_ready;
    dreq_t [n_dests-1:0]        m_data;
    logic                       cfg_wr;
    cfg_target_e                cfg_target;
    logic [dest_bits-1:0]       cfg_addr;
    logic [dest_bits-1:0]       cfg_data;
    logic [drop_count_bits-1:0] drop_count;

    // ############################################################
    // reference model state and scoreboard
    // ############################################################

    logic [dest_bits-1:0] model_map [n_logical_dests]; // expected remap table
    logic [n_dests-1:0]   model_en;                    // expected port enables
    int                   model_drops;                 // drops accepted so far
    dreq_t                exp_q [n_dests][$];          // expected words per port, in order
    int                   acc_q [n_dests][$];          // accept cycle of each expected word
    logic [31:0]          rng = 32'h130afb67;
    int                   cycle = 0;
    int                   mismatch_count = 0;
    int                   error_count = 0;
    logic                 lat_check = 1'b1;            // all ports ready, so latency is exact
    logic                 random_ready = 1'b0;         // m_ready follows the generator

    dreq_router_top #(
        .n_dests(n_dests)
    ) dreq_router_top_inst (
        .aclk       (aclk),
        .reset      (reset),
        .s_valid    (s_valid),
        .s_ready    (s_ready),
        .s_data     (s_data),
        .m_valid    (m_valid),
        .m_ready    (m_ready),
        .m_data     (m_data),
        .cfg_wr     (cfg_wr),
        .cfg_target (cfg_target),
        .cfg_addr   (cfg_addr),
        .cfg_data   (cfg_data),
        .drop_count (drop_count)
    );

    bind dreq_router_top dreq_router_props #(
        .n_dests(n_dests)
    ) dreq_router_props_inst (
        .aclk        (aclk),
        .reset       (reset),
        .s_valid     (s_valid),
        .s_ready     (s_ready),
        .m_valid     (m_valid),
        .m_ready     (m_ready),
        .m_data      (m_data),
        .slice_valid (dest_dreq_mux_inst.slice_valid),
        .slice_ready (dest_dreq_mux_inst.slice_ready),
        .drop_pulse  (drop_pulse)
    );

    always #5 aclk = ~aclk; // 10 ns period

    always @(posedge aclk) cycle <= cycle + 1;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic dreq_t rand_dreq();
        logic [127:0] r;
        dreq_t        d;
        for (int i = 0; i < 4; i++) begin
            r[i*32 +: 32] = next_rand();
        end
        d = dreq_t'(r[$bits(dreq_t)-1:0]);
        d.req_1.opcode = req_opcode_e'(next_rand() % 3); // keep opcodes inside the enum
        d.req_2.opcode = req_opcode_e'(next_rand() % 3);
        return d;
    endfunction

    // expected physical port of a word, or -1 when it must be dropped
    function automatic int expected_port(input dreq_t d);
        logic [dest_bits-1:0] dest;
        int                   phys;
        dest = d.req_1.actv ? d.req_1.dest : d.req_2.dest; // req_1 has priority when active
        phys = model_map[dest];
        if (phys >= n_dests) return -1;   // table names a port that does not exist
        if (!model_en[phys]) return -1;
        return phys;
    endfunction

    task automatic reset_model();
        for (int i = 0; i < n_logical_dests; i++) begin
            model_map[i] = dest_bits'(i % n_dests);
        end
        model_en    = '1;
        model_drops = 0;
    endtask

    task automatic apply_cfg_model(input cfg_target_e tgt, input logic [3:0] addr,
                                   input logic [3:0] data);
        if (tgt == cfg_map_entry) begin
            model_map[addr] = data;
        end else if (addr < n_dests) begin
            model_en[addr] = data[0]; // enable writes past the last port are lost
        end
    endtask

    task automatic check_dreq(input string name, input dreq_t got, input dreq_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_count(input logic [drop_count_bits-1:0] got,
                               input logic [drop_count_bits-1:0] exp);
        if (got !== exp) begin
            $display("MISMATCH drop_count got %h expected %h", got, exp);
            mismatch_count++;
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, error_count);
        if (mismatch_count == 0 && error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    // ############################################################
    // stimulus, inputs change 1 ns after the rising edge
    // ############################################################

    task automatic step();
        @(posedge aclk);
        #1;
        cfg_wr = 1'b0; // a strobe never lasts more than one cycle
        if (random_ready) m_ready = n_dests'(next_rand() | next_rand()); // mostly ready
        else m_ready = '1;
    endtask

    task automatic idle(input int n);
        s_valid = 1'b0;
        repeat (n) step();
    endtask

    task automatic cfg_write(input cfg_target_e tgt, input logic [3:0] addr,
                             input logic [3:0] data);
        cfg_wr     = 1'b1;
        cfg_target = tgt;
        cfg_addr   = addr;
        cfg_data   = data;
        step();
    endtask

    // holds the word until the DUT takes it
    task automatic send_req(input dreq_t d);
        logic accepted;
        s_data   = d;
        s_valid  = 1'b1;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge aclk);
            accepted = s_ready;
            step();
        end
        s_valid = 1'b0;
    endtask

    // ############################################################
    // monitor and compare, sampled on the falling edge
    // ############################################################

    always @(negedge aclk) begin : monitor
        int port;
        int acc;
        if (!reset) begin
            check_count(drop_count, drop_count_bits'(model_drops)); // earlier drops only
            for (int i = 0; i < n_dests; i++) begin
                if (m_valid[i] && m_ready[i]) begin
                    if (exp_q[i].size() == 0) begin
                        $display("port %0d delivered a word that was not expected", i);
                        error_count++;
                    end else begin
                        check_dreq($sformatf("m_data[%0d]", i), m_data[i], exp_q[i].pop_front());
                        acc = acc_q[i].pop_front();
                        if (lat_check && (acc + 1 != cycle)) begin
                            $display("port %0d word accepted in cycle %0d arrived in cycle %0d",
                                     i, acc, cycle);
                            error_count++;
                        end
                    end
                end
            end
            // a drop never waits, and with every port ready nothing may stall the input
            if (s_valid && !s_ready && (lat_check || expected_port(s_data) < 0)) begin
                $display("input stalled in cycle %0d although nothing should block it", cycle);
                error_count++;
            end
            if (s_valid && s_ready) begin
                port = expected_port(s_data); // table as it stood before this cycle's write
                if (port < 0) begin
                    model_drops++;
                end else begin
                    exp_q[port].push_back(s_data);
                    acc_q[port].push_back(cycle);
                end
            end
            if (cfg_wr) apply_cfg_model(cfg_target, cfg_addr, cfg_data);
        end
    end

    initial begin : watchdog
        wait (cycle >= timeout_limit);
        $display("timeout: run did not finish within %0d cycles", timeout_limit);
        error_count++;
        finish_run();
    end

    initial begin : main
        logic [31:0] r;
        reset      = 1'b1;
        s_valid    = 1'b0;
        s_data     = '0;
        m_ready    = '1;
        cfg_wr     = 1'b0;
        cfg_target = cfg_map_entry;
        cfg_addr   = '0;
        cfg_data   = '0;
        reset_model();
        repeat (reset_cycles) @(posedge aclk);
        #1;
        reset = 1'b0;
        check_count(drop_count, '0); // reset defaults

        // reset mapping, full throughput, one cycle latency
        for (int k = 0; k < n_basic; k++) send_req(rand_dreq());
        idle(4);

        // new table moves every entry, values 4 and 5 point past the last port
        for (int i = 0; i < n_logical_dests; i++) begin
            cfg_write(cfg_map_entry, 4'(i), 4'((i + 3) % 6));
        end
        for (int k = 0; k < n_remap; k++) send_req(rand_dreq());
        idle(2);

        cfg_write(cfg_port_enable, 4'd2, 4'd0);
        cfg_write(cfg_port_enable, 4'd9, 4'd0); // no such port, write is ignored
        for (int k = 0; k < n_disable; k++) send_req(rand_dreq());
        idle(4);
        check_count(drop_count, drop_count_bits'(model_drops));
        cfg_write(cfg_port_enable, 4'd2, 4'd1);

        // random back-pressure with strobes landing beside requests
        lat_check    = 1'b0;
        random_ready = 1'b1;
        for (int k = 0; k < n_random; k++) begin
            r = next_rand();
            if (r[2:0] == 3'd0) begin
                cfg_wr     = 1'b1;
                cfg_target = cfg_target_e'(r[3]);
                cfg_addr   = r[7:4];
                cfg_data   = r[3] ? {3'b000, r[8] | r[9]} : 4'(r[15:8] % 5);
            end
            send_req(rand_dreq());
            if (r[12:10] == 3'd0) idle(1);
        end

        random_ready = 1'b0; // drain everything still in the slices
        idle(10);
        for (int i = 0; i < n_dests; i++) begin
            if (exp_q[i].size() != 0) begin
                $display("port %0d still owes %0d words at end of run", i, exp_q[i].size());
                error_count++;
            end
        end
        check_count(drop_count, drop_count_bits'(model_drops));
        finish_run();
    end

endmodule

// ==== sim.f ====
src/dreq_pkg.sv
src/meta_reg.sv
src/dest_map_regs.sv
src/dest_dreq_mux.sv
src/dreq_router_top.sv
test/dreq_router_props.sv
test/dreq_router_tb.sv

// ==== Bender.yml ====
package:
  name: dreq_router

sources:
  # RTL in compile order
  - files:
      - src/dreq_pkg.sv
      - src/meta_reg.sv
      - src/dest_map_regs.sv
      - src/dest_dreq_mux.sv
      - src/dreq_router_top.sv

  # testbench and bound assertions
  - target: test
    files:
      - test/dreq_router_props.sv
      - test/dreq_router_tb.sv
